// ==== list.f ====
source/spi_pkg.sv
source/spi_sequencer.sv
source/spi_tx_shifter.sv
source/spi_rx_shifter.sv
source/spi_pin_stage.sv
source/spi_master_top.sv
sim/spi_peripheral_model.sv
sim/tb_spi_master.sv

// ==== sim/spi_peripheral_model.sv ====
//******************************
// SPI peripheral model
// Samples copi and drives cipo on the edges of the mode
//******************************
`timescale 1ns/1ns

module spi_peripheral_model #(
    parameter int MAX_WIDTH = 32
) (
    input  logic                       sclk,
    input  logic                       cs_n,
    input  logic                       copi,
    input  logic                       copi_en,
    input  logic                       cpol,
    input  logic                       cpha,
    input  logic [$clog2(MAX_WIDTH):0] width,
    input  logic [MAX_WIDTH-1:0]       reply,     // Sent MSB first
    output logic                       cipo,
    output logic [MAX_WIDTH-1:0]       copi_seen, // First sample ends up highest
    output logic [MAX_WIDTH-1:0]       en_seen,
    output int                         samples
);
    logic selected;
    logic last_sclk;
    int   next_bit; // Reply bit for the next shift edge

    initial begin
        cipo      = 1'b0;
        copi_seen = '0;
        en_seen   = '0;
        samples   = 0;
        selected  = 1'b0;
        last_sclk = 1'b0;
        next_bit  = -1;
        forever begin
            @(sclk or cs_n);
            #1; // Let the pins settle
            if (cs_n) begin
                selected = 1'b0;
            end else if (!selected) begin
                // Select edge, sclk already parked at CPOL
                selected  = 1'b1;
                last_sclk = sclk;
                copi_seen = '0;
                en_seen   = '0;
                samples   = 0;
                next_bit  = int'(width) - 1;
                if (!cpha) begin
                    cipo     = reply[next_bit]; // First bit out at select
                    next_bit = next_bit - 1;
                end
            end else if (sclk != last_sclk) begin
                last_sclk = sclk;
                if ((sclk != cpol) != cpha) begin // Sample edge of this mode
                    copi_seen = {copi_seen[MAX_WIDTH-2:0], copi};
                    en_seen   = {en_seen[MAX_WIDTH-2:0], copi_en};
                    samples   = samples + 1;
                end else begin
                    cipo     = (next_bit >= 0) ? reply[next_bit] : 1'b0;
                    next_bit = next_bit - 1;
                end
            end
        end
    end
endmodule : spi_peripheral_model

// ==== sim/tb_spi_master.sv ====
//******************************
// SPI controller testbench
// Random transfers in all modes against a peripheral model
//******************************
`timescale 1ns/1ns

module tb_spi_master;
    localparam int MAX_WIDTH = 32;
    localparam int WB = $clog2(MAX_WIDTH) + 1;
    localparam int LIMIT = 4000; // Cycles allowed per wait

    logic clk, rst_n, clk_en, start_req, start_ack, start_nak, cpol, cpha;
    logic end_req, end_ack, cs_override, sclk, cs_n, copi, copi_en, cipo;
    logic [spi_pkg::DIV_WIDTH-1:0] clock_divisor;
    logic [WB-1:0] width;
    logic [MAX_WIDTH-1:0] copi_data, copi_mask, cipo_mask, cipo_data;
    logic [MAX_WIDTH-1:0] reply, copi_seen, en_seen;
    int samples;
    logic gaps_on = 1'b0;   // Random clk_en low cycles
    logic period_on = 1'b0; // Half-period check armed
    logic have_edge = 1'b0;
    logic last_sclk = 1'b0;
    logic prev_cs_n = 1'b1;
    int cnt = 0;

    spi_master_top #(.MAX_WIDTH(MAX_WIDTH)) spi_master_top_i (.*);
    spi_peripheral_model #(.MAX_WIDTH(MAX_WIDTH)) peripheral_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        #1;
        clk_en = gaps_on ? ($urandom_range(3) != 0) : 1'b1;
    end

    task automatic check_word(input string name, input logic [MAX_WIDTH-1:0] got, exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "%s wrong", name);
        end
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "%s wrong", name);
        end
    endtask

    task automatic report_timeout(input string what);
        spi_pkg::seq_state_e st;
        st = spi_master_top_i.sequencer_i.state;
        $display("Timed out waiting for %s, sequencer in %s", what, st.name());
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    endtask

    // Kept reply bits in sample order, packed into the LSBs
    function automatic logic [MAX_WIDTH-1:0] expect_cipo(input logic [MAX_WIDTH-1:0] word,
                                                         input int w,
                                                         input logic [MAX_WIDTH-1:0] keep);
        logic [MAX_WIDTH-1:0] r;
        int k;
        r = '0;
        for (k = 0; k < w; k++) begin
            if (keep[k]) r = {r[MAX_WIDTH-2:0], word[w-1-k]}; // Sample k is bit w-1-k
        end
        return r;
    endfunction

    // Copi stream MSB first, low where masked
    function automatic logic [MAX_WIDTH-1:0] expect_copi(input logic [MAX_WIDTH-1:0] bits,
                                                         input int w,
                                                         input logic [MAX_WIDTH-1:0] mask);
        logic [MAX_WIDTH-1:0] r;
        int k;
        r = '0;
        for (k = w - 1; k >= 0; k--) r = {r[MAX_WIDTH-2:0], bits[k] & mask[k]};
        return r;
    endfunction

    // Half-period monitor, edges inside one select only
    always @(negedge clk) begin
        if (!cs_n && !prev_cs_n && sclk != last_sclk) begin
            if (have_edge && period_on) begin
                check_word("sclk half-period", MAX_WIDTH'(cnt), MAX_WIDTH'(clock_divisor));
            end
            have_edge = 1'b1;
            cnt = 0;
        end
        if (cs_n) have_edge = 1'b0;
        cnt++;
        last_sclk = sclk;
        prev_cs_n = cs_n;
    end

    task automatic refuse_width(input int w);
        @(posedge clk);
        #1;
        width = WB'(w);
        start_req = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_bit("start_nak", start_nak, 1'b1);
            check_bit("start_ack", start_ack, 1'b0);
            check_bit("cs_n", cs_n, 1'b1);
        end
        @(posedge clk);
        #1;
        start_req = 1'b0;
    endtask

    task automatic run_transfer(input logic m_cpol, m_cpha, input int w, div,
                                input logic gaps, override);
        logic [MAX_WIDTH-1:0] held;
        int n;
        @(posedge clk);
        #1;
        cpol = m_cpol;
        cpha = m_cpha;
        width = WB'(w);
        clock_divisor = spi_pkg::DIV_WIDTH'(div);
        copi_data = $urandom();
        copi_mask = $urandom();
        cipo_mask = $urandom();
        reply = $urandom();
        gaps_on = gaps;
        period_on = !gaps;
        cs_override = override;
        start_req = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(clk_en && start_ack) && n < LIMIT);
        if (!(clk_en && start_ack)) report_timeout("start_ack");
        @(posedge clk);
        #1;
        start_req = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (override) check_bit("cs_n", cs_n, 1'b1);
        end while (!end_req && n < LIMIT);
        if (!end_req) report_timeout("end_req");
        check_bit("sclk", sclk, m_cpol); // Back at rest
        if (!override) begin
            check_word("copi", copi_seen, expect_copi(copi_data, w, copi_mask));
            check_word("copi_en", en_seen, expect_copi(copi_mask, w, '1));
            check_word("samples", MAX_WIDTH'(samples), MAX_WIDTH'(w));
            check_word("cipo_data", cipo_data, expect_cipo(reply, w, cipo_mask));
        end
        held = cipo_data;
        @(posedge clk);
        #1;
        start_req = 1'b1; // Must wait for end_ack
        repeat ($urandom_range(2, 5)) begin
            @(negedge clk);
            check_bit("end_req", end_req, 1'b1);
            check_bit("start_ack", start_ack, 1'b0);
            check_word("cipo_data", cipo_data, held);
        end
        @(posedge clk);
        #1;
        start_req = 1'b0;
        end_ack = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (end_req && n < LIMIT);
        if (end_req) report_timeout("end_req to drop");
        @(posedge clk);
        #1;
        end_ack = 1'b0;
        cs_override = 1'b0;
    endtask

    initial begin
        int i;
        void'($urandom(32'h6623_d4e2));
        rst_n = 1'b0;
        clk_en = 1'b1;
        start_req = 1'b0;
        end_ack = 1'b0;
        cs_override = 1'b0;
        cpol = 1'b0;
        cpha = 1'b0;
        width = WB'(1);
        clock_divisor = spi_pkg::DIV_WIDTH'(1);
        copi_data = '0;
        copi_mask = '0;
        cipo_mask = '0;
        reply = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("start_nak", start_nak, 1'b0);
        check_bit("end_req", end_req, 1'b0);
        check_bit("cs_n", cs_n, 1'b1);
        check_bit("sclk", sclk, 1'b0);
        check_bit("copi", copi, 1'b0);
        check_bit("copi_en", copi_en, 1'b0);
        refuse_width(0);
        refuse_width(MAX_WIDTH + 1);
        refuse_width(2 ** WB - 1);
        for (i = 0; i < 24; i++) begin
            run_transfer(i[1], i[0], $urandom_range(1, MAX_WIDTH), $urandom_range(1, 4),
                         i % 3 == 2, i % 7 == 6);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end
endmodule : tb_spi_master

// ==== source/spi_master_top.sv ====
//******************************
// SPI controller top level
// Sequencer, tx and rx shifters and pin stage
//******************************
`timescale 1ns/1ns

module spi_master_top #(
    parameter int MAX_WIDTH = 32,
    localparam int WIDTH_BITS = $clog2(MAX_WIDTH) + 1
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          clk_en,
    // Start handshake and transfer setup
    input  logic                          start_req,
    output logic                          start_ack,
    output logic                          start_nak,     // Width out of range
    input  logic [spi_pkg::DIV_WIDTH-1:0] clock_divisor,
    input  logic                          cpol,
    input  logic                          cpha,
    input  logic [WIDTH_BITS-1:0]         width,
    input  logic [MAX_WIDTH-1:0]          copi_data,
    input  logic [MAX_WIDTH-1:0]          copi_mask,
    input  logic [MAX_WIDTH-1:0]          cipo_mask,
    // Result handshake
    output logic                          end_req,
    input  logic                          end_ack,
    output logic [MAX_WIDTH-1:0]          cipo_data,
    // SPI pins
    input  logic                          cs_override,
    output logic                          sclk,
    output logic                          cs_n,
    output logic                          copi,
    output logic                          copi_en,
    input  logic                          cipo
);
    logic load;
    logic shift_strobe;
    logic sample_strobe;
    logic active;
    logic sclk_int;
    logic tx_bit;
    logic tx_bit_en;
    logic cipo_sync;

    spi_sequencer #(.MAX_WIDTH(MAX_WIDTH)) sequencer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .clk_en       (clk_en),
        .start_req    (start_req),
        .clock_divisor(clock_divisor),
        .cpol         (cpol),
        .cpha         (cpha),
        .width        (width),
        .end_ack      (end_ack),
        .start_ack    (start_ack),
        .start_nak    (start_nak),
        .end_req      (end_req),
        .load         (load),
        .shift_strobe (shift_strobe),
        .sample_strobe(sample_strobe),
        .active       (active),
        .sclk_int     (sclk_int)
    );

    spi_tx_shifter #(.MAX_WIDTH(MAX_WIDTH)) tx_shifter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .clk_en      (clk_en),
        .load        (load),
        .shift_strobe(shift_strobe),
        .width       (width),
        .copi_data   (copi_data),
        .copi_mask   (copi_mask),
        .tx_bit      (tx_bit),
        .tx_bit_en   (tx_bit_en)
    );

    spi_rx_shifter #(.MAX_WIDTH(MAX_WIDTH)) rx_shifter_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .clk_en       (clk_en),
        .load         (load),
        .sample_strobe(sample_strobe),
        .cipo_mask    (cipo_mask),
        .cipo_sync    (cipo_sync),
        .cipo_data    (cipo_data)
    );

    spi_pin_stage pin_stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .clk_en     (clk_en),
        .sclk_int   (sclk_int),
        .active     (active),
        .tx_bit     (tx_bit),
        .tx_bit_en  (tx_bit_en),
        .cs_override(cs_override),
        .cipo       (cipo),
        .sclk       (sclk),
        .cs_n       (cs_n),
        .copi       (copi),
        .copi_en    (copi_en),
        .cipo_sync  (cipo_sync)
    );

endmodule : spi_master_top

// ==== source/spi_pin_stage.sv ====
//******************************
// SPI pin stage
// Output pipeline for sclk, copi, copi_en, cs_n
// and the cipo synchronizer
//******************************
`timescale 1ns/1ns

module spi_pin_stage (
    input  logic clk,
    input  logic rst_n,
    input  logic clk_en,
    input  logic sclk_int,
    input  logic active,
    input  logic tx_bit,
    input  logic tx_bit_en,
    input  logic cs_override, // Holds cs_n high, transfer still runs
    input  logic cipo,
    output logic sclk,
    output logic cs_n,
    output logic copi,
    output logic copi_en,
    output logic cipo_sync
);
    localparam int PD = spi_pkg::SCLK_PIPE_DEPTH;
    localparam int SD = spi_pkg::CIPO_SYNC_DEPTH;

    logic          drive;     // Selected peripheral may be driven
    logic [PD-1:0] sclk_pipe;
    logic [PD-1:0] copi_pipe;
    logic [PD-1:0] en_pipe;
    logic [PD-1:0] cs_n_pipe;
    logic [SD-1:0] cipo_pipe;

    assign drive = active && !cs_override;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sclk_pipe <= '0;
            copi_pipe <= '0;
            en_pipe   <= '0;
            cs_n_pipe <= '1; // Deselected out of reset
        end else if (clk_en) begin
            for (int i = PD - 1; i > 0; i--) begin
                sclk_pipe[i] <= sclk_pipe[i-1];
                copi_pipe[i] <= copi_pipe[i-1];
                en_pipe[i]   <= en_pipe[i-1];
                cs_n_pipe[i] <= cs_n_pipe[i-1];
            end
            sclk_pipe[0] <= sclk_int;
            copi_pipe[0] <= tx_bit && drive;
            en_pipe[0]   <= tx_bit_en && drive;
            cs_n_pipe[0] <= !active || cs_override;
        end
    end

    // Asynchronous input
    always_ff @(posedge clk) begin
        if (clk_en) begin
            for (int i = SD - 1; i > 0; i--) begin
                cipo_pipe[i] <= cipo_pipe[i-1];
            end
            cipo_pipe[0] <= cipo;
        end
    end

    assign sclk      = sclk_pipe[PD-1];
    assign copi      = copi_pipe[PD-1];
    assign copi_en   = en_pipe[PD-1];
    assign cs_n      = cs_n_pipe[PD-1];
    assign cipo_sync = cipo_pipe[SD-1];

    // Never drive copi toward a deselected bus
    copi_en_selected: assert property (@(posedge clk) disable iff (!rst_n)
        cs_n |-> !copi_en);

endmodule : spi_pin_stage

// ==== source/spi_pkg.sv ====
//******************************
// SPI controller shared definitions
// Sequencer states, pin pipeline depths and divisor width
//******************************

package spi_pkg;

    // Sequencer states
    typedef enum logic [2:0] {
        IDLE  = 3'd0, // Waiting for start_req
        SETUP = 3'd1, // cs active, sclk parked at CPOL for one half-period
        SHIFT = 3'd2, // 2 x width sclk edges
        DRAIN = 3'd3, // Let the last sample work through the pin pipeline
        DONE  = 3'd4  // Result held until end_ack
    } seq_state_e;

    // Width of clock_divisor, one half-period of sclk in clk_en cycles
    localparam int DIV_WIDTH = 16;

    // clk_en cycles from sclk_int to the sclk pin
    localparam int SCLK_PIPE_DEPTH = 2;

    // Stages in the cipo synchronizer
    localparam int CIPO_SYNC_DEPTH = 2;

    // Round trip from a sample strobe to a stable cipo_sync bit
    // Sclk goes out through the pin pipeline, cipo comes back through the sync
    localparam int DRAIN_CYCLES = SCLK_PIPE_DEPTH + CIPO_SYNC_DEPTH;

endpackage : spi_pkg

// ==== source/spi_rx_shifter.sv ====
//******************************
// SPI receive shifter
// Delays sample strobes to the pin pipeline and shifts
// kept cipo bits into the LSB of the result
//******************************
`timescale 1ns/1ns

module spi_rx_shifter #(
    parameter int MAX_WIDTH = 32
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clk_en,
    input  logic                 load,
    input  logic                 sample_strobe,
    input  logic [MAX_WIDTH-1:0] cipo_mask,  // Bit k keeps the k-th sampled bit
    input  logic                 cipo_sync,
    output logic [MAX_WIDTH-1:0] cipo_data
);
    localparam int DLY = spi_pkg::DRAIN_CYCLES;

    logic [MAX_WIDTH-1:0] mask_q;
    logic [DLY-1:0]       strobe_dly; // Sample strobe, pin aligned at the top
    logic [DLY-1:0]       keep_dly;   // Its mask bit, same alignment
    logic                 loaded;     // Any transfer started since reset
    logic                 take_bit;

    assign take_bit = strobe_dly[DLY-1] && keep_dly[DLY-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            strobe_dly <= '0;
            keep_dly   <= '0;
            loaded     <= 1'b0;
        end else if (clk_en) begin
            strobe_dly <= {strobe_dly[DLY-2:0], sample_strobe};
            keep_dly   <= {keep_dly[DLY-2:0], mask_q[0]};
            if (load) begin
                loaded <= 1'b1;
            end
        end
    end

    // Mask walks LSB first, one place per sample
    // Result is zero based at every load
    always_ff @(posedge clk) begin
        if (clk_en) begin
            if (load) begin
                mask_q    <= cipo_mask;
                cipo_data <= '0;
            end else begin
                if (sample_strobe) begin
                    mask_q <= mask_q >> 1;
                end
                if (take_bit) begin
                    cipo_data <= {cipo_data[MAX_WIDTH-2:0], cipo_sync}; // Into the LSB
                end
            end
        end
    end

    // Strobes only come out of a loaded transfer
    strobe_after_load: assert property (@(posedge clk) disable iff (!rst_n)
        strobe_dly[DLY-1] |-> loaded);

endmodule : spi_rx_shifter

// ==== source/spi_sequencer.sv ====
//******************************
// SPI transfer sequencer
// Start/end handshakes, sclk divider, edge counter
// and CPHA mapping of edges to shift and sample strobes
//******************************
`timescale 1ns/1ns

module spi_sequencer #(
    parameter int MAX_WIDTH = 32,
    localparam int WIDTH_BITS = $clog2(MAX_WIDTH) + 1, // Room for widths above MAX_WIDTH
    localparam int EDGE_BITS = WIDTH_BITS + 1          // Holds 2 x width
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           clk_en,
    input  logic                           start_req,
    input  logic [spi_pkg::DIV_WIDTH-1:0]  clock_divisor, // Half-period in clk_en cycles
    input  logic                           cpol,
    input  logic                           cpha,
    input  logic [WIDTH_BITS-1:0]          width,
    input  logic                           end_ack,
    output logic                           start_ack,
    output logic                           start_nak,
    output logic                           end_req,
    output logic                           load,          // Accept strobe
    output logic                           shift_strobe,
    output logic                           sample_strobe,
    output logic                           active,        // Chip select, internal
    output logic                           sclk_int
);
    localparam logic [spi_pkg::DIV_WIDTH-1:0] DIV_ONE = 1;
    localparam int DRAIN_BITS = $clog2(spi_pkg::DRAIN_CYCLES + 1);

    spi_pkg::seq_state_e             state;
    logic                            cpha_q;        // Captured at load
    logic [spi_pkg::DIV_WIDTH-1:0]   half_q;        // Captured divisor, never 0
    logic [spi_pkg::DIV_WIDTH-1:0]   div_cnt;       // Counts down to the next tick
    logic [spi_pkg::DIV_WIDTH-1:0]   div_eff;
    logic [EDGE_BITS-1:0]            edges_left;
    logic                            first_pending; // No edge seen yet in SHIFT
    logic [DRAIN_BITS-1:0]           drain_cnt;
    logic                            width_ok;
    logic                            tick;
    logic                            edge_now;
    logic                            leading;
    logic                            trailing;
    logic                            last_edge;

    // Handshakes
    assign width_ok  = (width != '0) && (width <= MAX_WIDTH);
    assign start_ack = (state == spi_pkg::IDLE) && width_ok;
    assign start_nak = (state == spi_pkg::IDLE) && start_req && !width_ok;
    assign load      = start_req && start_ack; // Consumers qualify with clk_en
    assign end_req   = (state == spi_pkg::DONE);
    assign active    = (state == spi_pkg::SETUP) || (state == spi_pkg::SHIFT)
                    || (state == spi_pkg::DRAIN);

    assign div_eff = (clock_divisor == '0) ? DIV_ONE : clock_divisor; // 0 runs as 1

    // Edge decode
    // Even count left means the next edge leaves CPOL
    assign tick      = (div_cnt == '0);
    assign edge_now  = tick && (state == spi_pkg::SHIFT);
    assign leading   = edge_now && !edges_left[0];
    assign trailing  = edge_now && edges_left[0];
    assign last_edge = (edges_left == EDGE_BITS'(1));

    // CPHA 0: first bit already out from load, no shift after the last bit
    // CPHA 1: first bit also out from load, so the first leading edge only presents it
    assign shift_strobe  = cpha_q ? (leading && !first_pending) : (trailing && !last_edge);
    assign sample_strobe = cpha_q ? trailing : leading;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= spi_pkg::IDLE;
            sclk_int      <= 1'b0; // Rests low until the first transfer
            cpha_q        <= 1'b0;
            half_q        <= DIV_ONE;
            div_cnt       <= '0;
            edges_left    <= '0;
            first_pending <= 1'b0;
            drain_cnt     <= '0;
        end else if (clk_en) begin
            case (state)
                spi_pkg::IDLE: begin
                    if (load) begin
                        state         <= spi_pkg::SETUP;
                        cpha_q        <= cpha;
                        half_q        <= div_eff;
                        div_cnt       <= div_eff - DIV_ONE;
                        sclk_int      <= cpol; // Park at the new CPOL
                        edges_left    <= {width, 1'b0};
                        first_pending <= 1'b1;
                    end
                end
                spi_pkg::SETUP: begin
                    if (tick) begin
                        state   <= spi_pkg::SHIFT;
                        div_cnt <= half_q - DIV_ONE;
                    end else begin
                        div_cnt <= div_cnt - DIV_ONE;
                    end
                end
                spi_pkg::SHIFT: begin
                    if (tick) begin
                        div_cnt       <= half_q - DIV_ONE;
                        sclk_int      <= ~sclk_int; // Even edge count lands back on CPOL
                        edges_left    <= edges_left - EDGE_BITS'(1);
                        first_pending <= 1'b0;
                        if (last_edge) begin
                            state     <= spi_pkg::DRAIN;
                            drain_cnt <= DRAIN_BITS'(spi_pkg::DRAIN_CYCLES - 1);
                        end
                    end else begin
                        div_cnt <= div_cnt - DIV_ONE;
                    end
                end
                spi_pkg::DRAIN: begin
                    if (drain_cnt == '0) begin
                        state <= spi_pkg::DONE;
                    end else begin
                        drain_cnt <= drain_cnt - DRAIN_BITS'(1);
                    end
                end
                spi_pkg::DONE: begin
                    if (end_ack) begin
                        state <= spi_pkg::IDLE; // Host took the result
                    end
                end
                default: state <= spi_pkg::IDLE;
            endcase
        end
    end

    // Result is held until the host takes it
    end_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        end_req && !(clk_en && end_ack) |=> end_req);

    ack_nak_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(start_ack && start_nak));

endmodule : spi_sequencer

// ==== source/spi_tx_shifter.sv ====
//******************************
// SPI transmit shifter
// Left-aligns copi data and mask by width at load,
// presents one bit per shift strobe, MSB first
//******************************
`timescale 1ns/1ns

module spi_tx_shifter #(
    parameter int MAX_WIDTH = 32,
    localparam int WIDTH_BITS = $clog2(MAX_WIDTH) + 1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clk_en,
    input  logic                  load,
    input  logic                  shift_strobe,
    input  logic [WIDTH_BITS-1:0] width,
    input  logic [MAX_WIDTH-1:0]  copi_data,
    input  logic [MAX_WIDTH-1:0]  copi_mask,
    output logic                  tx_bit,
    output logic                  tx_bit_en
);
    logic [MAX_WIDTH-1:0]  data_q;
    logic [MAX_WIDTH-1:0]  mask_q;
    logic [WIDTH_BITS-1:0] align; // Moves bit width-1 up to the MSB

    // Only meaningful for accepted widths 1..MAX_WIDTH
    assign align = WIDTH_BITS'(MAX_WIDTH) - width;

    // Mask decides copi_en
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mask_q <= '0;
        end else if (clk_en) begin
            if (load) begin
                mask_q <= copi_mask << align;
            end else if (shift_strobe) begin
                mask_q <= {mask_q[MAX_WIDTH-2:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en) begin
            if (load) begin
                data_q <= copi_data << align;
            end else if (shift_strobe) begin
                data_q <= {data_q[MAX_WIDTH-2:0], 1'b0}; // Next bit to the top
            end
        end
    end

    // Registered source, so both follow a strobe by one clk_en cycle
    assign tx_bit_en = mask_q[MAX_WIDTH-1];
    assign tx_bit    = data_q[MAX_WIDTH-1] && tx_bit_en; // Low where masked off

endmodule : spi_tx_shifter
